// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - files:
      - verilog/rv_isa_pkg.sv
      - verilog/rv_bus_pkg.sv
      - verilog/rv_regfile.sv
      - verilog/rv_decode.sv
      - verilog/rv_alu.sv
      - verilog/rv_lsu.sv
      - verilog/rv_control.sv
      - verilog/rv_core_top.sv
  - target: test
    files:
      - dv/rv_core_tb.sv

// ==== dv/rv_core_tb.sv ====
`default_nettype none

module rv_core_tb;
    import rv_isa_pkg::*;
    import rv_bus_pkg::*;

    localparam int period     = 4;
    localparam int drive_dly  = 1;
    localparam int imem_words = 256;
    localparam int data_base  = 64;

    // what the model expects from the instruction at m_pc
    typedef struct packed {
        logic       wr;
        word_t      wr_val;
        logic       mvalid;
        logic       mwrite;
        word_t      maddr;
        word_t      mwdata;
        logic [3:0] mbe;
        word_t      npc;
    } step_t;

    logic        clk;
    logic        rst;
    imem_req_t   imem_req;
    word_t       instr;
    dmem_req_t   dmem_req;
    word_t       dmem_rdata;
    logic        retire;
    word_t       retire_pc;

    word_t       imem [imem_words];
    logic [7:0]  dmem [256];
    logic [7:0]  m_mem [256];
    word_t       m_regs [32];
    word_t       m_pc;
    word_t       m_instr;
    step_t       exp_s;
    word_t       halt_pc;
    int          prog_len;
    logic [31:0] seed;
    imem_req_t   ireq_q;
    dmem_req_t   dreq_q;

    rv_core_top rv_core_top_inst (
        .clk        (clk),
        .rst        (rst),
        .imem_req   (imem_req),
        .instr      (instr),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .retire     (retire),
        .retire_pc  (retire_pc)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1);
    endtask

    function automatic string mismatch_line(input string name, input word_t e, input word_t g);
        return $sformatf("MISMATCH %s expected %h got %h", name, e, g);
    endfunction

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic word_t lane_mask(input logic [3:0] be);
        word_t m;
        for (int i = 0; i < 4; i++)
            m[8*i +: 8] = {8{be[i]}};
        return m;
    endfunction

    function automatic word_t r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                     input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), op_reg};
    endfunction

    function automatic word_t i_type(input word_t imm, input int rs1, input logic [2:0] f3,
                                     input int rd, input logic [6:0] op);
        return {imm[11:0], 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic word_t s_type(input word_t imm, input int rs2, input int rs1,
                                     input logic [2:0] f3);
        return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], op_store};
    endfunction

    function automatic word_t b_type(input word_t imm, input int rs2, input int rs1,
                                     input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic word_t j_type(input word_t imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), op_jal};
    endfunction

    task automatic emit(input word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    function automatic step_t predict_step(input word_t w);
        step_t      s;
        logic [6:0] op;
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      ea;
        word_t      sra_v;
        logic [7:0] byte_v;
        logic       taken;
        op    = w[6:0];
        f3    = w[14:12];
        f7    = w[31:25];
        a     = m_regs[w[19:15]];
        b     = m_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        s     = '0;
        s.npc = m_pc + 32'd4;
        case (op)
            op_reg, op_imm: begin
                if (op == op_imm)
                    b = imm_i;
                if (op == op_reg)
                    s.wr = (f7 == 7'h00) || (f7 == funct7_alt && (f3 == 3'b000 || f3 == 3'b101));
                else if (f3 == 3'b001)
                    s.wr = (f7 == 7'h00);
                else if (f3 == 3'b101)
                    s.wr = (f7 == 7'h00) || (f7 == funct7_alt);
                else
                    s.wr = 1'b1;
                sra_v = $signed(a) >>> b[4:0];
                case (f3)
                    3'b000:  s.wr_val = (op == op_reg && f7 == funct7_alt) ? a - b : a + b;
                    3'b001:  s.wr_val = a << b[4:0];
                    3'b010:  s.wr_val = {31'b0, $signed(a) < $signed(b)};
                    3'b011:  s.wr_val = {31'b0, a < b};
                    3'b100:  s.wr_val = a ^ b;
                    3'b101:  s.wr_val = (f7 == funct7_alt) ? sra_v : a >> b[4:0];
                    3'b110:  s.wr_val = a | b;
                    default: s.wr_val = a & b;
                endcase
            end
            op_load: begin
                ea       = a + imm_i;
                s.maddr  = {ea[31:2], 2'b00};
                s.mvalid = (f3 == 3'b000) || (f3 == 3'b010) || (f3 == 3'b100);
                s.wr     = s.mvalid;
                byte_v   = m_mem[ea[7:0]];
                case (f3)
                    3'b000:  s.wr_val = {{24{byte_v[7]}}, byte_v};
                    3'b100:  s.wr_val = {24'b0, byte_v};
                    default: s.wr_val = {m_mem[s.maddr[7:0] + 8'd3], m_mem[s.maddr[7:0] + 8'd2],
                                         m_mem[s.maddr[7:0] + 8'd1], m_mem[s.maddr[7:0]]};
                endcase
            end
            op_store: begin
                ea       = a + {{20{w[31]}}, w[31:25], w[11:7]};
                s.maddr  = {ea[31:2], 2'b00};
                s.mwrite = 1'b1;
                s.mvalid = (f3 == 3'b000) || (f3 == 3'b010 && ea[1:0] == 2'b00);
                s.mbe    = (f3 == 3'b000) ? 4'b0001 << ea[1:0] : 4'b1111;
                s.mwdata = (f3 == 3'b000) ? {4{b[7:0]}} : b; // lane picked by mbe
            end
            op_branch: begin
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = $signed(a) < $signed(b);
                    3'b101:  taken = $signed(a) >= $signed(b);
                    3'b110:  taken = a < b;
                    3'b111:  taken = a >= b;
                    default: taken = 1'b0;
                endcase
                if (taken)
                    s.npc = m_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            op_jal: begin
                s.wr     = 1'b1;
                s.wr_val = m_pc + 32'd4;
                s.npc    = m_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            op_lui: begin
                s.wr     = 1'b1;
                s.wr_val = {w[31:12], 12'b0};
            end
            default: s.wr = 1'b0; // anything else retires as a nop
        endcase
        return s;
    endfunction

    task automatic retire_model();
        if (exp_s.wr && m_instr[11:7] != 5'd0)
            m_regs[m_instr[11:7]] = exp_s.wr_val;
        if (exp_s.mvalid && exp_s.mwrite) begin
            for (int i = 0; i < 4; i++)
                if (exp_s.mbe[i])
                    m_mem[exp_s.maddr[7:0] + 8'(i)] = exp_s.mwdata[8*i +: 8];
        end
        m_pc    = exp_s.npc;
        m_instr = imem[m_pc[9:2]];
        exp_s   = predict_step(m_instr);
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] r2;
        int          rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [2:0]  br_kinds [6] = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
        int          br_a [3] = '{2, 3, 2};
        int          br_b [3] = '{3, 2, 2};
        logic [6:0]  bad_ops [3] = '{7'b1111111, 7'b1100111, 7'b0010111}; // jalr, auipc
        for (int i = 2; i < 10; i++) begin
            r = next_rand();
            emit({r[31:12], 5'(i), op_lui});
            emit(i_type({20'b0, 12'(next_rand() >> 20)}, i, f3_add, i, op_imm));
        end
        emit(i_type(data_base, 0, f3_add, 1, op_imm)); // x1 is the data base
        for (int k = 0; k < 24; k++) begin
            r  = next_rand();
            r2 = next_rand();
            rd = 10 + k % 8;
            f3 = r[24:22];
            f7 = (r[21] && (f3 == f3_add || f3 == f3_srl)) ? funct7_alt : 7'h00;
            if (r[20])
                emit(r_type(f7, 2 + r[27:25], 2 + r[30:28], f3, rd));
            else if (f3 == f3_sll || f3 == f3_srl)
                emit(i_type({20'b0, f7, r[19:15]}, 2 + r[30:28], f3, rd, op_imm));
            else
                emit(i_type({20'b0, r2[31:20]}, 2 + r[30:28], f3, rd, op_imm));
            emit(s_type(4 * (k % 8), rd, 1, f3_sw));
        end
        for (int k = 0; k < 4; k++) begin
            emit(s_type(32 + k, 2 + k, 1, f3_sb));
            emit(i_type(32 + k, 1, f3_lb, 20, op_load));
            emit(s_type(36, 20, 1, f3_sw));
            emit(i_type(32 + k, 1, f3_lbu, 21, op_load));
            emit(s_type(40, 21, 1, f3_sw));
            emit(i_type(32, 1, f3_lw, 22, op_load));
            emit(s_type(44, 22, 1, f3_sw));
        end
        foreach (br_kinds[j])
            for (int p = 0; p < 3; p++) begin
                emit(b_type(8, br_b[p], br_a[p], br_kinds[j]));
                emit(i_type(1, 23, f3_add, 23, op_imm)); // skipped when taken
            end
        emit(s_type(48, 23, 1, f3_sw));
        emit(j_type(8, 24));
        emit(i_type(1, 24, f3_add, 24, op_imm));
        emit(s_type(52, 24, 1, f3_sw));
        emit(i_type(5, 2, f3_add, 0, op_imm)); // x0 target
        emit(s_type(56, 0, 1, f3_sw));
        emit(i_type(4, 1, 3'b001, 2, op_load)); // lh is not kept
        foreach (bad_ops[j]) begin
            r = next_rand();
            emit({r[31:12], 5'd2, bad_ops[j]});
        end
        emit(s_type(60, 2, 1, f3_sw));
        emit(s_type(2, 3, 1, f3_sw)); // misaligned, dropped
        halt_pc = 32'(prog_len * 4);
        emit(j_type(0, 0));
    endtask

    always @(posedge clk) begin
        ireq_q = imem_req;
        dreq_q = dmem_req;
        #drive_dly;
        if (ireq_q.valid)
            instr = imem[ireq_q.addr[9:2]];
        if (dreq_q.valid && dreq_q.write) begin
            for (int i = 0; i < 4; i++)
                if (dreq_q.byte_en[i])
                    dmem[dreq_q.addr[7:0] + 8'(i)] = dreq_q.wdata[8*i +: 8];
        end else if (dreq_q.valid) begin
            dmem_rdata = {dmem[dreq_q.addr[7:0] + 8'd3], dmem[dreq_q.addr[7:0] + 8'd2],
                          dmem[dreq_q.addr[7:0] + 8'd1], dmem[dreq_q.addr[7:0]]};
        end
    end

    always @(posedge clk) begin
        if (!rst && retire)
            retire_model();
    end

    reset_quiet: assert property (@(posedge clk)
        rst |-> !imem_req.valid && !dmem_req.valid && !retire)
        else stop_on_error("a strobe was active during reset");

    first_fetch: assert property (@(posedge clk)
        $fell(rst) |-> (!imem_req.valid && !dmem_req.valid && !retire)
            ##1 (imem_req.valid && imem_req.addr == '0))
        else stop_on_error("first fetch after reset was late, early or not at address 0");

    retire_spacing: assert property (@(posedge clk) disable iff (rst)
        retire |=> !retire [*4] ##1 retire)
        else stop_on_error("retire pulses were not five cycles apart");

    retire_pc_ok: assert property (@(posedge clk) disable iff (rst)
        retire |-> retire_pc == m_pc)
        else stop_on_error(mismatch_line("retire_pc", $sampled(m_pc), $sampled(retire_pc)));

    fetch_addr_ok: assert property (@(posedge clk) disable iff (rst)
        imem_req.valid |-> imem_req.addr == m_pc)
        else stop_on_error(mismatch_line("imem_req.addr", $sampled(m_pc),
                                         $sampled(imem_req.addr)));

    dmem_slot_ok: assert property (@(posedge clk) disable iff (rst)
        dmem_req.valid |=> retire)
        else stop_on_error("a data request was issued outside the memory state");

    dmem_valid_ok: assert property (@(posedge clk) disable iff (rst)
        retire |-> $past(dmem_req.valid) == exp_s.mvalid)
        else stop_on_error(mismatch_line("dmem_req.valid", $sampled(exp_s.mvalid),
                                         $past(dmem_req.valid)));

    dmem_write_ok: assert property (@(posedge clk) disable iff (rst)
        dmem_req.valid |-> dmem_req.write == exp_s.mwrite)
        else stop_on_error(mismatch_line("dmem_req.write", $sampled(exp_s.mwrite),
                                         $sampled(dmem_req.write)));

    dmem_addr_ok: assert property (@(posedge clk) disable iff (rst)
        dmem_req.valid |-> dmem_req.addr == exp_s.maddr)
        else stop_on_error(mismatch_line("dmem_req.addr", $sampled(exp_s.maddr),
                                         $sampled(dmem_req.addr)));

    dmem_be_ok: assert property (@(posedge clk) disable iff (rst)
        dmem_req.valid && dmem_req.write |-> dmem_req.byte_en == exp_s.mbe)
        else stop_on_error(mismatch_line("dmem_req.byte_en", $sampled(exp_s.mbe),
                                         $sampled(dmem_req.byte_en)));

    dmem_wdata_ok: assert property (@(posedge clk) disable iff (rst)
        dmem_req.valid && dmem_req.write |->
            (dmem_req.wdata & lane_mask(exp_s.mbe)) == (exp_s.mwdata & lane_mask(exp_s.mbe)))
        else stop_on_error(mismatch_line("dmem_req.wdata",
            $sampled(exp_s.mwdata) & lane_mask($sampled(exp_s.mbe)),
            $sampled(dmem_req.wdata) & lane_mask($sampled(exp_s.mbe))));

    initial begin
        rst        = 1'b1;
        instr      = '0;
        dmem_rdata = '0;
        seed       = 32'haf46a9dd;
        prog_len   = 0;
        for (int i = 0; i < imem_words; i++)
            imem[i] = {25'(i * 32'h9e3779b9), 7'b0000000}; // opcode 0 decodes as nop
        for (int i = 0; i < 256; i++) begin
            dmem[i]  = 8'(i ^ (i >> 3) ^ 8'h5a);
            m_mem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++)
            m_regs[i] = '0;
        build_program();
        m_pc    = '0;
        m_instr = imem[0];
        exp_s   = predict_step(m_instr);
        fork
            begin
                #((prog_len * 5 + 40) * period);
                stop_on_error("timeout, the program never reached its final jump");
            end
        join_none
        repeat (3) @(posedge clk);
        #drive_dly;
        rst = 1'b0;
        wait (m_pc == halt_pc);
        repeat (12) @(posedge clk); // let the halt loop retire a few times
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
verilog/rv_isa_pkg.sv
verilog/rv_bus_pkg.sv
verilog/rv_regfile.sv
verilog/rv_decode.sv
verilog/rv_alu.sv
verilog/rv_lsu.sv
verilog/rv_control.sv
verilog/rv_core_top.sv
dv/rv_core_tb.sv

// ==== verilog/rv_alu.sv ====
`default_nettype none

module rv_alu (
    input  wire rv_isa_pkg::decoded_t dec,
    input  wire rv_isa_pkg::word_t    rs1_data,
    input  wire rv_isa_pkg::word_t    rs2_data,
    output rv_isa_pkg::word_t         result,
    output logic                      branch_taken
);
    import rv_isa_pkg::*;

    word_t      op_b;
    logic [4:0] shamt;
    logic       alt;
    word_t      sra_out;
    word_t      alu_out;
    logic       cond;

    assign op_b  = (dec.opcode == op_reg) ? rs2_data : dec.imm;
    assign shamt = op_b[4:0];

    // sub only in R-type, sra/srai in both
    assign alt = dec.funct7_alt && (dec.opcode == op_reg || dec.funct3 == f3_srl);

    assign sra_out = $signed(rs1_data) >>> shamt;

    always_comb begin
        case (dec.funct3)
            f3_add:  alu_out = alt ? rs1_data - op_b : rs1_data + op_b;
            f3_sll:  alu_out = rs1_data << shamt;
            f3_slt:  alu_out = word_t'($signed(rs1_data) < $signed(op_b));
            f3_sltu: alu_out = word_t'(rs1_data < op_b);
            f3_xor:  alu_out = rs1_data ^ op_b;
            f3_srl:  alu_out = alt ? sra_out : rs1_data >> shamt;
            f3_or:   alu_out = rs1_data | op_b;
            f3_and:  alu_out = rs1_data & op_b;
            default: alu_out = '0;
        endcase
    end

    always_comb begin
        case (dec.opcode)
            op_reg, op_imm:    result = alu_out;
            op_load, op_store: result = rs1_data + dec.imm; // effective address
            op_lui:            result = dec.imm;
            default:           result = '0;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            f3_beq:  cond = (rs1_data == rs2_data);
            f3_bne:  cond = (rs1_data != rs2_data);
            f3_blt:  cond = ($signed(rs1_data) < $signed(rs2_data));
            f3_bge:  cond = ($signed(rs1_data) >= $signed(rs2_data));
            f3_bltu: cond = (rs1_data < rs2_data);
            f3_bgeu: cond = (rs1_data >= rs2_data);
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken = (dec.opcode == op_branch) && cond;

endmodule

`default_nettype wire

// ==== verilog/rv_bus_pkg.sv ====
`default_nettype none

package rv_bus_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int be_w   = data_w / 8;

    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
    } imem_req_t;

    typedef struct packed {
        logic              valid;
        logic              write;
        logic [addr_w-1:0] addr;    // low two bits always zero
        logic [data_w-1:0] wdata;
        logic [be_w-1:0]   byte_en;
    } dmem_req_t;

endpackage

`default_nettype wire

// ==== verilog/rv_control.sv ====
`default_nettype none

module rv_control (
    input  wire                       clk,
    input  wire                       rst,
    output logic                      decode_en,
    input  wire rv_isa_pkg::decoded_t dec,
    input  wire rv_isa_pkg::word_t    alu_result,
    input  wire                       branch_taken,
    output logic                      mem_en,
    input  wire rv_isa_pkg::word_t    load_data,
    output logic                      wr_en,
    output rv_isa_pkg::reg_idx_t      wr_idx,
    output rv_isa_pkg::word_t         wr_data,
    output rv_bus_pkg::imem_req_t     imem_req,
    output logic                      retire,
    output rv_isa_pkg::word_t         retire_pc
);
    import rv_isa_pkg::*;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback
    } state_t;

    state_t state;
    logic   started; // first fetch waits one cycle after reset
    word_t  pc;
    word_t  pc_plus4;
    word_t  next_pc;
    word_t  exec_result;
    logic   writes_rd;

    assign pc_plus4 = pc + 32'd4;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= st_fetch;
            started <= 1'b0;
            pc      <= '0;
            next_pc <= '0;
        end else begin
            started <= 1'b1;
            case (state)
                st_fetch: begin
                    if (started)
                        state <= st_decode;
                end
                st_decode: state <= st_execute;
                st_execute: begin
                    state <= st_memory;
                    if (branch_taken || dec.opcode == op_jal)
                        next_pc <= pc + dec.imm;
                    else
                        next_pc <= pc_plus4;
                end
                st_memory: state <= st_writeback;
                st_writeback: begin
                    state <= st_fetch;
                    pc    <= next_pc;
                end
                default: state <= st_fetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_execute)
            exec_result <= alu_result;
    end

    always_comb begin
        imem_req.valid = started && (state == st_fetch);
        imem_req.addr  = pc;
    end

    assign decode_en = (state == st_decode);
    assign mem_en    = (state == st_memory) && (dec.opcode == op_load || dec.opcode == op_store);

    always_comb begin
        case (dec.opcode)
            op_reg, op_imm, op_lui: begin
                writes_rd = 1'b1;
                wr_data   = exec_result;
            end
            op_load: begin
                writes_rd = 1'b1;
                wr_data   = load_data;
            end
            op_jal: begin
                writes_rd = 1'b1;
                wr_data   = pc_plus4; // link
            end
            default: begin
                writes_rd = 1'b0; // stores, branches, nop
                wr_data   = exec_result;
            end
        endcase
    end

    assign wr_en     = (state == st_writeback) && writes_rd;
    assign wr_idx    = dec.rd;
    assign retire    = (state == st_writeback);
    assign retire_pc = pc;

    retire_not_in_mem: assert property (@(posedge clk) disable iff (rst) !(retire && mem_en));

endmodule

`default_nettype wire

// ==== verilog/rv_core_top.sv ====
`default_nettype none

module rv_core_top (
    input  wire                    clk,
    input  wire                    rst,
    output rv_bus_pkg::imem_req_t  imem_req,
    input  wire rv_isa_pkg::word_t instr,
    output rv_bus_pkg::dmem_req_t  dmem_req,
    input  wire rv_isa_pkg::word_t dmem_rdata,
    output logic                   retire,
    output rv_isa_pkg::word_t      retire_pc
);
    import rv_isa_pkg::*;

    logic     decode_en;
    decoded_t dec;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    alu_result;
    logic     branch_taken;
    logic     mem_en;
    word_t    load_data;
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;

    rv_control rv_control_inst (
        .clk          (clk),
        .rst          (rst),
        .decode_en    (decode_en),
        .dec          (dec),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .mem_en       (mem_en),
        .load_data    (load_data),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_data      (wr_data),
        .imem_req     (imem_req),
        .retire       (retire),
        .retire_pc    (retire_pc)
    );

    rv_decode rv_decode_inst (
        .clk       (clk),
        .rst       (rst),
        .decode_en (decode_en),
        .instr     (instr),
        .dec       (dec)
    );

    rv_regfile rv_regfile_inst (
        .clk      (clk),
        .rst      (rst),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data)
    );

    rv_alu rv_alu_inst (
        .dec          (dec),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    // address comes straight from the alu, stable through the memory state
    rv_lsu rv_lsu_inst (
        .clk        (clk),
        .rst        (rst),
        .mem_en     (mem_en),
        .dec        (dec),
        .addr       (alu_result),
        .store_data (rs2_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .load_data  (load_data)
    );

endmodule

`default_nettype wire

// ==== verilog/rv_decode.sv ====
`default_nettype none

module rv_decode (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       decode_en,
    input  wire rv_isa_pkg::word_t    instr,
    output rv_isa_pkg::decoded_t      dec
);
    import rv_isa_pkg::*;

    instr_fields_t f;
    logic          legal;
    word_t         imm;

    assign f = instr_fields_t'(instr);

    always_comb begin
        case (f.opcode)
            op_reg: begin
                legal = (f.funct7 == '0) ||
                        (f.funct7 == funct7_alt && (f.funct3 == f3_add || f.funct3 == f3_srl));
            end
            op_imm: begin
                if (f.funct3 == f3_sll)
                    legal = (f.funct7 == '0);
                else if (f.funct3 == f3_srl)
                    legal = (f.funct7 == '0) || (f.funct7 == funct7_alt);
                else
                    legal = 1'b1;
            end
            op_load:  legal = (f.funct3 == f3_lb) || (f.funct3 == f3_lw) || (f.funct3 == f3_lbu);
            op_store: legal = (f.funct3 == f3_sb) || (f.funct3 == f3_sw);
            op_branch: begin
                case (f.funct3)
                    f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu: legal = 1'b1;
                    default: legal = 1'b0;
                endcase
            end
            op_jal, op_lui: legal = 1'b1;
            default:        legal = 1'b0;
        endcase
    end

    always_comb begin
        case (f.opcode)
            op_imm, op_load: imm = {{20{instr[31]}}, instr[31:20]};
            op_store:        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            op_branch:       imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            op_jal:          imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            op_lui:          imm = {instr[31:12], 12'b0};
            default:         imm = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec <= '0; // opcode of zero is the nop
        end else if (decode_en) begin
            dec.opcode     <= legal ? f.opcode : op_nop;
            dec.rd         <= f.rd;
            dec.rs1        <= f.rs1;
            dec.rs2        <= f.rs2;
            dec.funct3     <= f.funct3;
            dec.funct7_alt <= (f.funct7 == funct7_alt);
            dec.imm        <= imm;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 1 << reg_addr_w;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_nop    = 7'b0000000; // illegal encodings decode to this

    // alu
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101; // also sra
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // loads and stores
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_sb  = 3'b000;
    localparam logic [2:0] f3_sw  = 3'b010;

    // branches
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [6:0] funct7_alt = 7'b0100000; // sub, sra, srai

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } instr_fields_t;

    typedef struct packed {
        logic [6:0] opcode;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [2:0] funct3;
        logic       funct7_alt;
        word_t      imm;
    } decoded_t;

endpackage

`default_nettype wire

// ==== verilog/rv_lsu.sv ====
`default_nettype none

module rv_lsu (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       mem_en,
    input  wire rv_isa_pkg::decoded_t dec,
    input  wire rv_isa_pkg::word_t    addr,
    input  wire rv_isa_pkg::word_t    store_data,
    output rv_bus_pkg::dmem_req_t     dmem_req,
    input  wire rv_isa_pkg::word_t    dmem_rdata,
    output rv_isa_pkg::word_t         load_data
);
    import rv_isa_pkg::*;
    import rv_bus_pkg::*;

    logic       is_store;
    logic [1:0] lane;
    logic       misaligned_sw;
    logic       ld_pending;
    logic [1:0] ld_lane;
    logic [2:0] ld_funct3;
    logic [7:0] ld_byte;

    assign is_store      = (dec.opcode == op_store);
    assign lane          = addr[1:0];
    assign misaligned_sw = is_store && dec.funct3 == f3_sw && lane != 2'b00;

    always_comb begin
        dmem_req.valid = mem_en && !misaligned_sw; // bad sw is dropped
        dmem_req.write = is_store;
        dmem_req.addr  = {addr[addr_w-1:2], 2'b00};
        if (dec.funct3 == f3_sb) begin
            dmem_req.wdata   = data_w'(store_data[7:0]) << {lane, 3'b000};
            dmem_req.byte_en = be_w'(1) << lane;
        end else begin
            dmem_req.wdata   = store_data;
            dmem_req.byte_en = '1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            ld_pending <= 1'b0;
        else
            ld_pending <= mem_en && (dec.opcode == op_load);
    end

    // lane and width for the data returning next cycle
    always_ff @(posedge clk) begin
        if (mem_en) begin
            ld_lane   <= lane;
            ld_funct3 <= dec.funct3;
        end
    end

    assign ld_byte = dmem_rdata[{ld_lane, 3'b000} +: 8];

    always_comb begin
        if (!ld_pending) begin
            load_data = '0;
        end else begin
            case (ld_funct3)
                f3_lb:   load_data = {{24{ld_byte[7]}}, ld_byte};
                f3_lbu:  load_data = {24'b0, ld_byte};
                f3_lw:   load_data = dmem_rdata;
                default: load_data = '0;
            endcase
        end
    end

    // a full word write must come from an aligned effective address
    store_req_ok: assert property (@(posedge clk) disable iff (rst)
        (dmem_req.valid && dmem_req.write) |->
            (dmem_req.byte_en != '1 || addr[1:0] == 2'b00) && (dmem_req.byte_en != '0));

endmodule

`default_nettype wire

// ==== verilog/rv_regfile.sv ====
`default_nettype none

module rv_regfile (
    input  wire                       clk,
    input  wire                       rst,
    input  wire rv_isa_pkg::reg_idx_t rs1,
    input  wire rv_isa_pkg::reg_idx_t rs2,
    output rv_isa_pkg::word_t         rs1_data,
    output rv_isa_pkg::word_t         rs2_data,
    input  wire                       wr_en,
    input  wire rv_isa_pkg::reg_idx_t wr_idx,
    input  wire rv_isa_pkg::word_t    wr_data
);
    import rv_isa_pkg::*;

    word_t regs [num_regs];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++)
                regs[i] <= '0;
        end else if (wr_en && wr_idx != '0) begin // x0 stays zero
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    // no write from any path may ever land in x0
    x0_reads_zero: assert property (@(posedge clk) disable iff (rst)
        ((rs1 == '0) |-> (rs1_data == '0)) and ((rs2 == '0) |-> (rs2_data == '0)));

endmodule

`default_nettype wire
